// ==== rtl/regex_settings.svh ====
// Widths and sizes shared by the text-search front end.
// Included by the package and by any module that sizes storage from it.

`ifndef REGEX_SETTINGS_SVH
`define REGEX_SETTINGS_SVH

// register interface
`define REG_WIDTH 32

// mixed-width memory, 64-bit read side and 32-bit write side
`define MEM_READ_WIDTH 64
`define MEM_WRITE_WIDTH 32
`define MEM_READ_ADDR_WIDTH 9
`define MEM_WRITE_ADDR_WIDTH 10
`define MEM_DEPTH (1 << `MEM_READ_ADDR_WIDTH)

// literal matcher
`define CHAR_WIDTH 8
`define MAX_PATTERN_LEN 7

`endif

// ==== rtl/regex_pkg.sv ====
// Types and command codes for the text-search front end.
// Modules import it inside their bodies and use scoped names on their ports.

`include "regex_settings.svh"

package regex_pkg;

    typedef logic [`REG_WIDTH-1:0]            reg_word_t;
    typedef logic [`MEM_READ_WIDTH-1:0]       mem_word_t;
    typedef logic [`MEM_WRITE_WIDTH-1:0]      half_word_t;
    typedef logic [`MEM_READ_ADDR_WIDTH-1:0]  rd_addr_t;
    typedef logic [`MEM_WRITE_ADDR_WIDTH-1:0] wr_addr_t;
    typedef logic [`CHAR_WIDTH-1:0]           char_t;

    // software command codes, held on the cmd register
    typedef logic [`REG_WIDTH-1:0] cmd_t;
    localparam cmd_t CMD_NOP          = 32'h0000_0000;
    localparam cmd_t CMD_WRITE        = 32'h0000_0001;
    localparam cmd_t CMD_READ         = 32'h0000_0002;
    localparam cmd_t CMD_START        = 32'h0000_0003;
    localparam cmd_t CMD_RESET        = 32'h0000_0004;
    localparam cmd_t CMD_READ_ELAPSED = 32'h0000_0005;
    localparam cmd_t CMD_RESTART      = 32'h0000_0006;

    // status register codes as seen by software
    typedef enum logic [`REG_WIDTH-1:0] {
        IDLE     = 32'd0,
        RUNNING  = 32'd1,
        ACCEPTED = 32'd2,
        REJECTED = 32'd3,
        ERROR    = 32'd4
    } status_t;

    typedef enum logic [2:0] {FETCH_PATTERN, FETCH_TEXT, WAIT_DATA, SCAN, FINISH} match_state_t;

endpackage

// ==== rtl/command_controller.sv ====
// Command decoder and status FSM of the search front end.
// Turns level-held software commands into memory accesses and search starts,
// and gives the memory read port to the matcher while a search runs.

`timescale 1ns/1ps

module command_controller (
    input  logic                   clk,
    input  logic                   rst_master,
    input  regex_pkg::reg_word_t   cmd,
    input  regex_pkg::reg_word_t   address,
    input  regex_pkg::reg_word_t   data_in,
    input  regex_pkg::mem_word_t   rd_data,
    input  regex_pkg::reg_word_t   elapsed,
    input  logic                   mem_req_valid,
    input  regex_pkg::rd_addr_t    mem_req_addr,
    input  logic                   start_ready,
    input  logic                   done,
    input  logic                   accept,
    input  logic                   error,
    output logic                   core_rst,
    output regex_pkg::status_t     status,
    output regex_pkg::reg_word_t   data_o,
    output logic                   wr_en,
    output regex_pkg::wr_addr_t    wr_addr,
    output regex_pkg::half_word_t  wr_data,
    output logic                   rd_en,
    output regex_pkg::rd_addr_t    rd_addr,
    output logic                   mem_req_ready,
    output logic                   start_valid,
    output logic                   count_clear,
    output logic                   count_enable
);

    import regex_pkg::*;

    status_t status_next;
    logic    half_sel_q;

    // a held RESET acts like the external reset, memory excluded
    assign core_rst = rst_master || (cmd == CMD_RESET);

    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            status <= IDLE;
        end
        else
        begin
            status <= status_next;
        end
    end

    // picks the 32-bit half of the read word, lines up with rd_data
    always_ff @(posedge clk)
    begin
        half_sel_q <= address[0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        status_next   = status;
        data_o        = '0;
        wr_en         = 1'b0;
        wr_addr       = wr_addr_t'(address);
        wr_data       = half_word_t'(data_in);
        rd_en         = 1'b0;
        rd_addr       = rd_addr_t'(address >> 1);
        mem_req_ready = 1'b0;
        start_valid   = 1'b0;
        count_clear   = 1'b0;
        count_enable  = 1'b0;

        case (status)
            RUNNING:
            begin
                // matcher owns the read port until done
                mem_req_ready = 1'b1;
                rd_en         = mem_req_valid;
                rd_addr       = mem_req_addr;
                count_enable  = 1'b1;
                if (done)
                begin
                    if (error)
                        status_next = ERROR;
                    else if (accept)
                        status_next = ACCEPTED;
                    else
                        status_next = REJECTED;
                end
            end
            default:
            begin
                // idle and the result states
                case (cmd)
                    CMD_WRITE:
                    begin
                        wr_en = 1'b1;
                    end
                    CMD_READ:
                    begin
                        rd_en  = 1'b1;
                        data_o = half_sel_q ? rd_data[63:32] : rd_data[31:0];
                    end
                    CMD_READ_ELAPSED:
                    begin
                        data_o = elapsed;
                    end
                    CMD_START:
                    begin
                        if (status == IDLE)
                        begin
                            start_valid   = 1'b1;
                            mem_req_ready = 1'b1;
                            rd_en         = mem_req_valid;
                            rd_addr       = mem_req_addr;
                            if (start_ready)
                            begin
                                count_clear = 1'b1;
                                status_next = RUNNING;
                            end
                        end
                    end
                    CMD_RESTART:
                    begin
                        if (status != IDLE)
                            status_next = IDLE;
                    end
                    default:
                    begin
                    end
                endcase
            end
        endcase
    end

endmodule

// ==== rtl/cycle_counter.sv ====
// Elapsed-cycle counter for search timing.
// Clear wins over enable; the count sticks at all ones instead of wrapping.

`timescale 1ns/1ps

module cycle_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  enable,
    output regex_pkg::reg_word_t  count
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0;
        end
        else if (enable && !(&count))
        begin
            // saturate
            count <= count + 1'b1;
        end
    end

endmodule

// ==== rtl/mixed_width_bram.sv ====
// Block-RAM style memory with a 32-bit write port and a 64-bit read port.
// Write word w goes to read word w/2, low half for even w.
// Read data is registered and holds while rd_en is low.

`timescale 1ns/1ps
`include "regex_settings.svh"

module mixed_width_bram (
    input  logic                   clk,
    input  logic                   wr_en,
    input  regex_pkg::wr_addr_t    wr_addr,
    input  regex_pkg::half_word_t  wr_data,
    input  logic                   rd_en,
    input  regex_pkg::rd_addr_t    rd_addr,
    output regex_pkg::mem_word_t   rd_data
);

    import regex_pkg::*;

    mem_word_t mem [`MEM_DEPTH];

    // write side, one half per access
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            if (wr_addr[0])
                mem[wr_addr[`MEM_WRITE_ADDR_WIDTH-1:1]][63:32] <= wr_data;
            else
                mem[wr_addr[`MEM_WRITE_ADDR_WIDTH-1:1]][31:0] <= wr_data;
        end
    end

    // read side
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/literal_matcher.sv ====
// Literal substring search engine.
// Word 0 of memory holds the length byte and up to seven pattern bytes;
// the text is scanned one character per cycle through a seven-deep window.
// Memory requests use valid/ready, data arrives one cycle after acceptance.

`timescale 1ns/1ps
`include "regex_settings.svh"

module literal_matcher (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_valid,
    input  regex_pkg::reg_word_t  start_cc_pointer,
    input  regex_pkg::reg_word_t  end_cc_pointer,
    input  logic                  mem_req_ready,
    input  regex_pkg::mem_word_t  rd_data,
    output logic                  start_ready,
    output logic                  mem_req_valid,
    output regex_pkg::rd_addr_t   mem_req_addr,
    output logic                  done,
    output logic                  accept,
    output logic                  error
);

    import regex_pkg::*;

    localparam int WIN_W = `CHAR_WIDTH * `MAX_PATTERN_LEN;

    match_state_t      state;
    logic              load_pattern;
    logic [2:0]        filled;
    reg_word_t         cur_ptr;
    reg_word_t         end_ptr;
    reg_word_t         ptr_next;
    char_t             len_q;
    char_t             cur_char;
    logic [WIN_W-1:0]  pattern_q;
    logic [WIN_W-1:0]  window_q;
    logic [WIN_W-1:0]  window_next;
    mem_word_t         text_word_q;
    logic              setup_bad;
    logic              hit;

    // finish doubles as the idle state
    assign start_ready   = (state == FINISH);
    assign mem_req_valid = (state == FETCH_PATTERN) || (state == FETCH_TEXT);
    assign mem_req_addr  = (state == FETCH_TEXT) ? cur_ptr[3 +: `MEM_READ_ADDR_WIDTH] : '0;

    assign cur_char  = text_word_q[{cur_ptr[2:0], 3'b000} +: `CHAR_WIDTH];
    assign ptr_next  = cur_ptr + 1'b1;
    assign setup_bad = (rd_data[7:0] == 8'd0) || (rd_data[7:0] > `MAX_PATTERN_LEN)
                       || (cur_ptr > end_ptr);

    // compare newest characters against the pattern, newest = last pattern char
    always_comb
    begin
        logic [2:0] p_idx;
        window_next = {window_q[WIN_W-`CHAR_WIDTH-1:0], cur_char};
        hit = ({1'b0, filled} + 4'd1) >= len_q[3:0];
        for (int j = 0; j < `MAX_PATTERN_LEN; j++)
        begin
            p_idx = 3'(len_q[2:0] - 3'd1 - 3'(j));
            if (j < len_q && window_next[j*`CHAR_WIDTH +: `CHAR_WIDTH]
                    != pattern_q[p_idx*`CHAR_WIDTH +: `CHAR_WIDTH])
                hit = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= FINISH;
            load_pattern <= 1'b0;
            filled       <= '0;
            done         <= 1'b0;
            accept       <= 1'b0;
            error        <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                FINISH:
                begin
                    if (start_valid)
                    begin
                        state  <= FETCH_PATTERN;
                        filled <= '0;
                        accept <= 1'b0;
                        error  <= 1'b0;
                    end
                end
                FETCH_PATTERN:
                begin
                    if (mem_req_ready)
                    begin
                        state        <= WAIT_DATA;
                        load_pattern <= 1'b1;
                    end
                end
                FETCH_TEXT:
                begin
                    if (mem_req_ready)
                    begin
                        state        <= WAIT_DATA;
                        load_pattern <= 1'b0;
                    end
                end
                WAIT_DATA:
                begin
                    if (!load_pattern)
                        state <= SCAN;
                    else if (setup_bad)
                    begin
                        state <= FINISH;
                        done  <= 1'b1;
                        error <= 1'b1;
                    end
                    else if (cur_ptr == end_ptr)
                    begin
                        // empty text never matches
                        state <= FINISH;
                        done  <= 1'b1;
                    end
                    else
                        state <= FETCH_TEXT;
                end
                SCAN:
                begin
                    if (filled != 3'd7)
                        filled <= filled + 3'd1;
                    if (hit)
                    begin
                        state  <= FINISH;
                        done   <= 1'b1;
                        accept <= 1'b1;
                    end
                    else if (ptr_next == end_ptr)
                    begin
                        state <= FINISH;
                        done  <= 1'b1;
                    end
                    else if (ptr_next[2:0] == 3'd0)
                        state <= FETCH_TEXT;
                end
                default:
                begin
                    state <= FINISH;
                end
            endcase
        end
    end

    // pointers, pattern and text data
    always_ff @(posedge clk)
    begin
        if (state == FINISH && start_valid)
        begin
            cur_ptr <= start_cc_pointer;
            end_ptr <= end_cc_pointer;
        end
        if (state == WAIT_DATA)
        begin
            if (load_pattern)
            begin
                len_q     <= rd_data[7:0];
                pattern_q <= rd_data[63:8];
            end
            else
                text_word_q <= rd_data;
        end
        if (state == SCAN)
        begin
            window_q <= window_next;
            cur_ptr  <= ptr_next;
        end
    end

endmodule

// ==== rtl/regex_accel_top.sv ====
// Top level of the text-search front end.
// Software registers in, status and read data out; memory contents
// survive the soft reset.

`timescale 1ns/1ps

module regex_accel_top (
    input  logic                  clk,
    input  logic                  rst_master,
    input  regex_pkg::reg_word_t  data_in,
    input  regex_pkg::reg_word_t  address,
    input  regex_pkg::reg_word_t  start_cc_pointer,
    input  regex_pkg::reg_word_t  end_cc_pointer,
    input  regex_pkg::reg_word_t  cmd,
    output regex_pkg::status_t    status,
    output regex_pkg::reg_word_t  data_o
);

    import regex_pkg::*;

    logic       core_rst;
    logic       wr_en;
    wr_addr_t   wr_addr;
    half_word_t wr_data;
    logic       rd_en;
    rd_addr_t   rd_addr;
    mem_word_t  rd_data;
    logic       mem_req_valid;
    logic       mem_req_ready;
    rd_addr_t   mem_req_addr;
    logic       start_valid;
    logic       start_ready;
    logic       done;
    logic       accept;
    logic       error;
    logic       count_clear;
    logic       count_enable;
    reg_word_t  elapsed;

    command_controller ctrl_i (
        .clk           (clk),
        .rst_master    (rst_master),
        .cmd           (cmd),
        .address       (address),
        .data_in       (data_in),
        .rd_data       (rd_data),
        .elapsed       (elapsed),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .start_ready   (start_ready),
        .done          (done),
        .accept        (accept),
        .error         (error),
        .core_rst      (core_rst),
        .status        (status),
        .data_o        (data_o),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .mem_req_ready (mem_req_ready),
        .start_valid   (start_valid),
        .count_clear   (count_clear),
        .count_enable  (count_enable)
    );

    cycle_counter counter_i (
        .clk    (clk),
        .rst    (core_rst),
        .clear  (count_clear),
        .enable (count_enable),
        .count  (elapsed)
    );

    mixed_width_bram bram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    literal_matcher matcher_i (
        .clk              (clk),
        .rst              (core_rst),
        .start_valid      (start_valid),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .mem_req_ready    (mem_req_ready),
        .rd_data          (rd_data),
        .start_ready      (start_ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .done             (done),
        .accept           (accept),
        .error            (error)
    );

endmodule

// ==== tests/regex_accel_assertions.sv ====
// Protocol checks on the command controller.
// Bound into every command_controller instance.

`timescale 1ns/1ps

module regex_accel_assertions (
    input logic                clk,
    input logic                rst,
    input regex_pkg::status_t  status,
    input logic                start_valid,
    input logic                wr_en
);

    import regex_pkg::*;

    // only the five software codes
    status_legal: assert property (@(posedge clk) disable iff (rst)
        status inside {IDLE, RUNNING, ACCEPTED, REJECTED, ERROR})
        else $error("status holds an illegal code %0h", status);

    // a search can only be offered from idle
    start_only_idle: assert property (@(posedge clk) disable iff (rst)
        start_valid |-> status == IDLE)
        else $error("start_valid raised while status is %0h", status);

    // memory writes are locked out during a search
    no_write_running: assert property (@(posedge clk) disable iff (rst)
        status == RUNNING |-> !wr_en)
        else $error("wr_en raised while a search is running");

endmodule

bind command_controller regex_accel_assertions assert_i (
    .clk         (clk),
    .rst         (core_rst),
    .status      (status),
    .start_valid (start_valid),
    .wr_en       (wr_en)
);

// ==== tests/regex_accel_tb.sv ====
// Testbench for the text-search front end.
// Drives the register ports with level-held commands, mirrors every memory
// write in a byte model and checks search results against a reference function.

`timescale 1ns/1ps
`include "regex_settings.svh"

module regex_accel_tb;

    import regex_pkg::*;

    localparam int MAX_TEXT_LEN   = 96;
    localparam int NUM_SEARCHES   = 7;
    localparam int POLL_LIMIT     = 8 * MAX_TEXT_LEN + 50;
    localparam int WATCHDOG_LIMIT = NUM_SEARCHES * (8 * MAX_TEXT_LEN + 50) + 400;
    localparam int TEXT_BASE      = 16;

    logic      clk = 1'b0;
    logic      rst_master;
    reg_word_t data_in;
    reg_word_t address;
    reg_word_t start_cc_pointer;
    reg_word_t end_cc_pointer;
    reg_word_t cmd;
    status_t   status;
    reg_word_t data_o;

    // byte image of the memory, little-endian within words
    bit [7:0]  mem_model [`MEM_DEPTH * 8];
    int        errors = 0;
    int        checks = 0;
    reg_word_t rdata;
    reg_word_t elapsed;
    int        start_ptr;

    regex_accel_top dut_i (
        .clk              (clk),
        .rst_master       (rst_master),
        .data_in          (data_in),
        .address          (address),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .cmd              (cmd),
        .status           (status),
        .data_o           (data_o)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic half_word_t model_word(input int w);
        return {mem_model[4*w+3], mem_model[4*w+2], mem_model[4*w+1], mem_model[4*w]};
    endfunction

    function automatic status_t expected_status(input int s, input int e);
        int   len;
        logic found;
        logic same;
        len   = mem_model[0];
        found = 1'b0;
        if (len == 0 || len > `MAX_PATTERN_LEN || s > e)
            return ERROR;
        for (int i = s; i + len <= e; i++)
        begin
            same = 1'b1;
            for (int k = 0; k < len; k++)
                if (mem_model[i+k] != mem_model[1+k])
                    same = 1'b0;
            if (same)
                found = 1'b1;
        end
        if (found)
            return ACCEPTED;
        else
            return REJECTED;
    endfunction

    task automatic check(input string name, input reg_word_t expected,
                         input reg_word_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // command driver
    ////////////////////////////////////////////////////////////////////////////

    // four cycles of the command, then two of NOP; q is data_o in the last one
    task automatic hold_cmd(input reg_word_t c, input reg_word_t a, input reg_word_t d,
                            output reg_word_t q);
        @(posedge clk);
        cmd     <= c;
        address <= a;
        data_in <= d;
        repeat (3) @(posedge clk);
        @(negedge clk);
        q = data_o;
        @(posedge clk);
        cmd <= CMD_NOP;
        @(posedge clk);
    endtask

    task automatic write_word(input int w, input half_word_t value);
        reg_word_t unused;
        for (int i = 0; i < 4; i++)
            mem_model[4*w+i] = value[8*i +: 8];
        hold_cmd(CMD_WRITE, w, value, unused);
    endtask

    task automatic read_check(input string name, input int w);
        reg_word_t q;
        hold_cmd(CMD_READ, w, 0, q);
        check(name, model_word(w), q);
    endtask

    // length byte, then seven upper case pattern characters
    task automatic load_pattern(input int len);
        mem_model[0] = 8'(len);
        for (int k = 1; k < 8; k++)
            mem_model[k] = 8'h41 + 8'($urandom_range(25));
        write_word(0, model_word(0));
        write_word(1, model_word(1));
    endtask

    // lower case text; a negative plant_at leaves the pattern out
    task automatic load_text(input int s, input int n, input int plant_at);
        for (int i = 0; i < n; i++)
            mem_model[s+i] = 8'h61 + 8'($urandom_range(25));
        if (plant_at >= 0)
            for (int k = 0; k < mem_model[0]; k++)
                mem_model[s+plant_at+k] = mem_model[1+k];
        for (int w = s / 4; w <= (s + n - 1) / 4; w++)
            write_word(w, model_word(w));
    endtask

    // start, then poll with READ_ELAPSED held until the search ends
    task automatic run_search(input string name, input int s, input int e,
                              output reg_word_t cycles);
        status_t   expected;
        reg_word_t unused;
        int        n;
        expected = expected_status(s, e);
        n        = 0;
        @(posedge clk);
        start_cc_pointer <= s;
        end_cc_pointer   <= e;
        hold_cmd(CMD_START, 0, 0, unused);
        @(posedge clk);
        cmd <= CMD_READ_ELAPSED;
        @(negedge clk);
        while (status == RUNNING && n < POLL_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (status == RUNNING)
        begin
            errors++;
            $display("%s did not finish within %0d cycles", name, POLL_LIMIT);
        end
        cycles = data_o;
        check(name, expected, status);
        @(posedge clk);
        cmd <= CMD_NOP;
        @(posedge clk);
    endtask

    task automatic restart_idle(input string name);
        reg_word_t unused;
        hold_cmd(CMD_RESTART, 0, 0, unused);
        @(negedge clk);
        check(name, IDLE, status);
    endtask

    initial
    begin
        rst_master       = 1'b1;
        cmd              = CMD_NOP;
        address          = '0;
        data_in          = '0;
        start_cc_pointer = '0;
        end_cc_pointer   = '0;
        void'($urandom(32'h5f7d4650));
        repeat (8) @(posedge clk);
        rst_master <= 1'b0;

        // even and odd write words share read words
        for (int i = 0; i < 6; i++)
            write_word(800 + i, $urandom);
        for (int i = 0; i < 6; i++)
            read_check("memory round trip", 800 + i);

        load_pattern(4);
        start_ptr = TEXT_BASE + $urandom_range(7);
        load_text(start_ptr, 40, $urandom_range(36));
        run_search("accepted search", start_ptr, start_ptr + 40, elapsed);
        check("accepted search elapsed in range", 1, elapsed >= 1 && elapsed <= 8 * 40 + 20);
        read_check("text read in result state", start_ptr / 4 + 1);
        restart_idle("restart after accept");

        load_text(start_ptr, 48, -1);
        run_search("rejected search", start_ptr, start_ptr + 48, elapsed);
        check("rejected search elapsed in range", 1, elapsed >= 1 && elapsed <= 8 * 48 + 20);
        restart_idle("restart after reject");
        run_search("empty text search", start_ptr, start_ptr, elapsed);
        restart_idle("restart after empty text");

        load_pattern(0);
        run_search("length byte zero", start_ptr, start_ptr + 48, elapsed);
        restart_idle("restart after length zero");
        load_pattern(9);
        run_search("length byte nine", start_ptr, start_ptr + 48, elapsed);
        restart_idle("restart after length nine");
        load_pattern(3);
        run_search("reversed pointers", start_ptr + 10, start_ptr, elapsed);
        restart_idle("restart after reversed pointers");

        // soft reset in the middle of a long search
        load_pattern(5);
        load_text(TEXT_BASE, MAX_TEXT_LEN, -1);
        @(posedge clk);
        start_cc_pointer <= TEXT_BASE;
        end_cc_pointer   <= TEXT_BASE + MAX_TEXT_LEN;
        hold_cmd(CMD_START, 0, 0, rdata);
        @(negedge clk);
        check("long search running", RUNNING, status);
        hold_cmd(CMD_RESET, 0, 0, rdata);
        @(negedge clk);
        check("status after soft reset", IDLE, status);
        hold_cmd(CMD_READ_ELAPSED, 0, 0, rdata);
        check("elapsed after soft reset", 0, rdata);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_LIMIT) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/regex_pkg.sv
rtl/command_controller.sv
rtl/cycle_counter.sv
rtl/mixed_width_bram.sv
rtl/literal_matcher.sv
rtl/regex_accel_top.sv
tests/regex_accel_assertions.sv
tests/regex_accel_tb.sv

// ==== Bender.yml ====
package:
  name: regex_accel

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/regex_pkg.sv
      - rtl/command_controller.sv
      - rtl/cycle_counter.sv
      - rtl/mixed_width_bram.sv
      - rtl/literal_matcher.sv
      - rtl/regex_accel_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/regex_accel_assertions.sv
      - tests/regex_accel_tb.sv
